/* common/vgafb_macros.svh */
`ifndef VGAFB_MACROS_SVH
`define VGAFB_MACROS_SVH

// byte address width of the DRAM port
`define VGAFB_ADR_W 26

// width of the per-frame burst count
`define VGAFB_NBURST_W 18

// direct-mapped line cache size
// index taken from address bits 8:5
`define VGAFB_LINES 16

// 64-bit beats per 32-byte burst
`define VGAFB_BEATS 4

// one RGB565 pixel
`define VGAFB_PIX_W 16

`endif

/* common/fml_pkg.sv */
`include "vgafb_macros.svh"

package fml_pkg;

	// DRAM request toward the FML port
	// address is burst aligned (low 5 bits zero)
	typedef struct packed {
		logic [`VGAFB_ADR_W-1:0] adr;
		logic                    stb;
	} fml_req_t;

	// DRAM response
	// first beat comes with ack, three more follow back to back
	typedef struct packed {
		logic        ack;
		logic [63:0] dat;
	} fml_rsp_t;

	// line cache read request, 64-bit word aligned
	// stb held high keeps the addressed line locked
	typedef struct packed {
		logic                    stb;
		logic [`VGAFB_ADR_W-1:0] adr;
	} dcb_req_t;

	// line cache read response, one cycle after the request
	typedef struct packed {
		logic        hit;
		logic [63:0] dat;
	} dcb_rsp_t;

endpackage

/* common/vgafb_pkg.sv */
`include "vgafb_macros.svh"

package vgafb_pkg;

	// frame setup as seen by the fetcher
	// base sampled when base_ack pulses
	typedef struct packed {
		logic [`VGAFB_ADR_W-1:0]    base;
		logic [`VGAFB_NBURST_W-1:0] nbursts;
	} frame_cfg_t;

	// RGB565 pixel, red in the top bits
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} pixel_t;

	// fetch controller states
	// cache is tried first, DRAM only on a miss of the first word
	typedef enum logic [3:0] {
		IDLE     = 4'd0,
		TRYCACHE = 4'd1,
		CACHE1   = 4'd2,
		CACHE2   = 4'd3,
		CACHE3   = 4'd4,
		CACHE4   = 4'd5,
		FML1     = 4'd6,
		FML2     = 4'd7,
		FML3     = 4'd8,
		FML4     = 4'd9
	} fetch_state_e;

endpackage

/* vgafb/vgafb_fifo64to16.sv */
`timescale 1ns/10ps
`include "vgafb_macros.svh"

module vgafb_fifo64to16 import vgafb_pkg::*; (
	input  logic        sys_clk,
	input  logic        vga_rst,
	input  logic        wr_stb,
	input  logic [63:0] wr_dat,
	output logic        rd_valid,
	output pixel_t      rd_dat,
	input  logic        rd_next
);

	// one burst worth of words
	localparam int DEPTH = `VGAFB_BEATS;
	localparam int PTR_W = $clog2(DEPTH);

	logic [63:0]      storage [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [1:0]       slice;
	logic [PTR_W:0]   level;
	logic [63:0]      head;
	logic             pop_word;

	always_ff @(posedge sys_clk) begin
		if (wr_stb)
			storage[wr_ptr] <= wr_dat;
	end

	assign head = storage[rd_ptr];

	// most significant slice leaves first
	assign rd_dat = pixel_t'(head[{~slice, 4'b0000} +: `VGAFB_PIX_W]);

	// valid while any word is held
	assign rd_valid = (level != '0);

	// last slice of the head word taken
	assign pop_word = rd_valid && rd_next && (slice == 2'd3);

	always_ff @(posedge sys_clk) begin
		if (vga_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			slice <= 2'd0;
			level <= '0;
		end else begin
			if (wr_stb)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_valid && rd_next) begin
				slice <= slice + 2'd1;
				if (slice == 2'd3)
					rd_ptr <= rd_ptr + 1'b1;
			end
			// word count, write and pop may coincide
			case ({wr_stb, pop_word})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

/* vgafb/vgafb_pixelfeed.sv */
`timescale 1ns/10ps
`include "vgafb_macros.svh"

module vgafb_pixelfeed import fml_pkg::*, vgafb_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  logic       vga_rst,
	input  frame_cfg_t cfg,
	output logic       base_ack,
	output fml_req_t   fml_req,
	input  fml_rsp_t   fml_rsp,
	output dcb_req_t   dcb_req,
	input  dcb_rsp_t   dcb_rsp,
	output pixel_t     pixel,
	output logic       pixel_valid,
	input  logic       pixel_ack
);

	localparam int ADR_W = `VGAFB_ADR_W;
	localparam int NB_W  = `VGAFB_NBURST_W;

	// fsm outputs
	logic fml_stb;
	logic dcb_stb;
	logic fifo_stb;
	logic fifo_src_cache;
	logic next_burst;
	logic ignore_clear;

	fetch_state_e state;
	fetch_state_e next_state;

	logic [NB_W-1:0]  bcounter;
	logic             sof;
	logic [ADR_W-1:0] fml_adr;
	logic [1:0]       dcb_index;
	logic             ignore;

	logic        fifo_valid;
	logic        fifo_rst;
	logic [63:0] fifo_dat;

	// word source follows the fetch path
	assign fifo_dat = fifo_src_cache ? dcb_rsp.dat : fml_rsp.dat;

	// buffer also cleared by the system reset
	assign fifo_rst = sys_rst | vga_rst;

	vgafb_fifo64to16 vgafb_fifo64to16_inst (
		.sys_clk  (sys_clk),
		.vga_rst  (fifo_rst),
		.wr_stb   (fifo_stb),
		.wr_dat   (fifo_dat),
		.rd_valid (fifo_valid),
		.rd_dat   (pixel),
		.rd_next  (pixel_ack)
	);

	assign pixel_valid = fifo_valid;

	// burst counter, 1 .. nbursts
	// sof marks that the next burst starts a frame
	always_ff @(posedge sys_clk) begin
		if (sys_rst || vga_rst) begin
			bcounter <= NB_W'(1);
			sof <= 1'b1;
		end else if (next_burst) begin
			if (bcounter == cfg.nbursts) begin
				bcounter <= NB_W'(1);
				sof <= 1'b1;
			end else begin
				bcounter <= bcounter + NB_W'(1);
				sof <= 1'b0;
			end
		end
	end

	// base consumed with the first burst of the frame
	assign base_ack = sof & next_burst;

	// DRAM address, one burst of 32 bytes per step
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fml_adr <= '0;
		end else if (next_burst) begin
			if (sof)
				fml_adr <= cfg.base;
			else
				fml_adr <= fml_adr + ADR_W'(32);
		end
	end

	assign fml_req.adr = {fml_adr[ADR_W-1:5], 5'd0};
	assign fml_req.stb = fml_stb;

	// word index inside the line, counts while the cache is read
	always_ff @(posedge sys_clk) begin
		if (sys_rst || !dcb_stb)
			dcb_index <= 2'd0;
		else
			dcb_index <= dcb_index + 2'd1;
	end

	// always starts at the line start
	assign dcb_req.adr = {fml_adr[ADR_W-1:5], dcb_index, 3'b000};
	assign dcb_req.stb = dcb_stb;

	// keeps beats of an interrupted access out of the buffer
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			ignore <= 1'b0;
		else if (vga_rst)
			ignore <= 1'b1;
		else if (ignore_clear)
			ignore <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		fml_stb = 1'b0;
		dcb_stb = 1'b0;
		fifo_stb = 1'b0;
		fifo_src_cache = 1'b0;
		next_burst = 1'b0;
		ignore_clear = 1'b0;
		case (state)
			IDLE: begin
				// refill only once the buffer ran dry
				if (!fifo_valid && !vga_rst) begin
					next_burst = 1'b1;
					ignore_clear = 1'b1;
					next_state = TRYCACHE;
				end
			end
			TRYCACHE: begin
				dcb_stb = 1'b1;
				next_state = CACHE1;
			end
			CACHE1: begin
				fifo_src_cache = 1'b1;
				if (dcb_rsp.hit) begin
					dcb_stb = 1'b1;
					fifo_stb = !ignore;
					next_state = CACHE2;
				end else begin
					// miss, go to DRAM
					next_state = FML1;
				end
			end
			// line stays locked while dcb_stb is held
			// so the remaining words are hits
			CACHE2: begin
				dcb_stb = 1'b1;
				fifo_src_cache = 1'b1;
				fifo_stb = !ignore;
				next_state = CACHE3;
			end
			CACHE3: begin
				dcb_stb = 1'b1;
				fifo_src_cache = 1'b1;
				fifo_stb = !ignore;
				next_state = CACHE4;
			end
			CACHE4: begin
				fifo_src_cache = 1'b1;
				fifo_stb = !ignore;
				next_state = IDLE;
			end
			FML1: begin
				// hold the request until ack, first beat comes with it
				fml_stb = 1'b1;
				if (fml_rsp.ack) begin
					fifo_stb = !ignore;
					next_state = FML2;
				end
			end
			FML2: begin
				fifo_stb = !ignore;
				next_state = FML3;
			end
			FML3: begin
				fifo_stb = !ignore;
				next_state = FML4;
			end
			FML4: begin
				fifo_stb = !ignore;
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

/* src/vgafb_line_cache.sv */
`timescale 1ns/10ps
`include "vgafb_macros.svh"

module vgafb_line_cache import fml_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst,
	input  dcb_req_t dcb_req,
	output dcb_rsp_t dcb_rsp,
	input  fml_req_t fml_req,
	input  fml_rsp_t fml_rsp
);

	localparam int LINES  = `VGAFB_LINES;
	localparam int IDX_W  = $clog2(LINES);
	localparam int WORD_W = $clog2(`VGAFB_BEATS);
	// byte offset inside a line
	localparam int OFS_W  = WORD_W + 3;
	localparam int TAG_W  = `VGAFB_ADR_W - IDX_W - OFS_W;

	logic [63:0]      data_mem [LINES*`VGAFB_BEATS];
	logic [TAG_W-1:0] tag_mem [LINES];
	logic [LINES-1:0] line_valid;

	// read side split
	logic [IDX_W-1:0]  rd_idx;
	logic [WORD_W-1:0] rd_word;
	logic [TAG_W-1:0]  rd_tag;

	assign rd_idx  = dcb_req.adr[OFS_W +: IDX_W];
	assign rd_word = dcb_req.adr[3 +: WORD_W];
	assign rd_tag  = dcb_req.adr[`VGAFB_ADR_W-1 -: TAG_W];

	// registered lookup, one cycle latency
	always_ff @(posedge sys_clk) begin
		dcb_rsp.dat <= data_mem[{rd_idx, rd_word}];
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			dcb_rsp.hit <= 1'b0;
		else
			dcb_rsp.hit <= dcb_req.stb && line_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	end

	// fill snooped from the DRAM port
	logic              fill_arm;
	logic              fill_active;
	logic              fill_drop;
	logic [IDX_W-1:0]  fill_idx;
	logic [WORD_W-1:0] fill_word;
	logic [IDX_W-1:0]  ack_idx;
	logic              lock_hit;
	logic              wr_en;
	logic [IDX_W+WORD_W-1:0] wr_addr;

	assign ack_idx  = fml_req.adr[OFS_W +: IDX_W];
	assign fill_arm = fml_req.stb && fml_rsp.ack;
	// reader holds this line, leave it alone
	assign lock_hit = dcb_req.stb && (rd_idx == ack_idx);

	// beat 0 comes in the ack cycle itself
	assign wr_en   = fill_arm ? !lock_hit : (fill_active && !fill_drop);
	assign wr_addr = fill_arm ? {ack_idx, WORD_W'(0)} : {fill_idx, fill_word};

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fill_active <= 1'b0;
			fill_drop <= 1'b0;
			fill_word <= '0;
			line_valid <= '0;
		end else if (fill_arm) begin
			fill_active <= 1'b1;
			fill_drop <= lock_hit;
			fill_word <= WORD_W'(1);
			// line invalid until its last beat lands
			if (!lock_hit)
				line_valid[ack_idx] <= 1'b0;
		end else if (fill_active) begin
			fill_word <= fill_word + 1'b1;
			if (fill_word == WORD_W'(`VGAFB_BEATS-1)) begin
				fill_active <= 1'b0;
				if (!fill_drop)
					line_valid[fill_idx] <= 1'b1;
			end
		end
	end

	// line index and tag taken at ack
	always_ff @(posedge sys_clk) begin
		if (fill_arm)
			fill_idx <= ack_idx;
		if (fill_arm && !lock_hit)
			tag_mem[ack_idx] <= fml_req.adr[`VGAFB_ADR_W-1 -: TAG_W];
		if (wr_en)
			data_mem[wr_addr] <= fml_rsp.dat;
	end

endmodule

/* src/vgafb_fetch_top.sv */
`timescale 1ns/10ps

module vgafb_fetch_top import fml_pkg::*, vgafb_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  logic       vga_rst,
	input  frame_cfg_t cfg,
	output logic       base_ack,
	output fml_req_t   fml_req,
	input  fml_rsp_t   fml_rsp,
	output pixel_t     pixel,
	output logic       pixel_valid,
	input  logic       pixel_ack
);

	// cache read path between feed and cache
	dcb_req_t dcb_req;
	dcb_rsp_t dcb_rsp;

	vgafb_pixelfeed vgafb_pixelfeed_inst (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.vga_rst     (vga_rst),
		.cfg         (cfg),
		.base_ack    (base_ack),
		.fml_req     (fml_req),
		.fml_rsp     (fml_rsp),
		.dcb_req     (dcb_req),
		.dcb_rsp     (dcb_rsp),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.pixel_ack   (pixel_ack)
	);

	// cache snoops the same DRAM request and beats for fills
	vgafb_line_cache vgafb_line_cache_inst (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.dcb_req (dcb_req),
		.dcb_rsp (dcb_rsp),
		.fml_req (fml_req),
		.fml_rsp (fml_rsp)
	);

endmodule

/* dv/vgafb_properties.sv */
`timescale 1ns/10ps

module vgafb_properties import fml_pkg::*, vgafb_pkg::*; (
	input logic         sys_clk,
	input logic         sys_rst,
	input logic         vga_rst,
	input fml_req_t     fml_req,
	input fml_rsp_t     fml_rsp,
	input pixel_t       pixel,
	input logic         pixel_valid,
	input logic         pixel_ack,
	input fetch_state_e state,
	input logic         ignore
);

	// number of failed checks so far
	int violations = 0;

	// request held with a fixed address until acked, even under vga_rst
	dram_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fml_req.stb && !fml_rsp.ack |=> fml_req.stb && $stable(fml_req.adr))
	else begin
		violations++;
		$error("DRAM request dropped or moved before ack");
	end

	// stalled pixel stays put, vga_rst may flush it
	pixel_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pixel_valid && !pixel_ack && !vga_rst |=> pixel_valid && $stable(pixel))
	else begin
		violations++;
		$error("pixel changed or vanished while stalled");
	end

	// last word of either path goes straight back to idle
	// a kept burst leaves words in the buffer
	last_word: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(state == FML4 || state == CACHE4) && !ignore && !vga_rst
		|=> state == IDLE && pixel_valid)
	else begin
		violations++;
		$error("fetch fsm did not return to IDLE with the burst in the buffer");
	end

endmodule

bind vgafb_pixelfeed vgafb_properties vgafb_properties_inst (
	.sys_clk     (sys_clk),
	.sys_rst     (sys_rst),
	.vga_rst     (vga_rst),
	.fml_req     (fml_req),
	.fml_rsp     (fml_rsp),
	.pixel       (pixel),
	.pixel_valid (pixel_valid),
	.pixel_ack   (pixel_ack),
	.state       (state),
	.ignore      (ignore)
);

/* dv/vgafb_tb.sv */
`timescale 1ns/10ps
`include "vgafb_macros.svh"

module vgafb_tb import fml_pkg::*, vgafb_pkg::*; ();

	localparam int NUM_TESTS  = 6;
	localparam int RST_CYCLES = 16;

	// one row of the test table
	typedef struct packed {
		logic [`VGAFB_ADR_W-1:0]    base;
		logic [`VGAFB_NBURST_W-1:0] nbursts;
		logic [3:0]                 latency;
		logic                       gaps;
		logic [7:0]                 exp_reqs;
		logic                       mid_rst;
		logic [1:0]                 frames;
	} test_row_t;

	logic       sys_clk;
	logic       sys_rst;
	logic       vga_rst;
	frame_cfg_t cfg;
	logic       base_ack;
	fml_req_t   fml_req;
	fml_rsp_t   fml_rsp = '0;
	pixel_t     pixel;
	logic       pixel_valid;
	logic       pixel_ack;

	test_row_t table_rows [NUM_TESTS];
	string     test_names [NUM_TESTS];

	int seed = 85;
	int cur_latency = 2;
	int dram_wait = 0;
	int dram_beat = 0;
	logic [`VGAFB_ADR_W-1:0] dram_adr = '0;
	int req_total = 0;
	int base_total = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int row_errors = 0;
	int errors = 0;
	int failed_tests = 0;

	vgafb_fetch_top vgafb_fetch_top_inst (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.vga_rst     (vga_rst),
		.cfg         (cfg),
		.base_ack    (base_ack),
		.fml_req     (fml_req),
		.fml_rsp     (fml_rsp),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.pixel_ack   (pixel_ack)
	);

	// beat k of burst at byte address a, four pixels, first one on top
	function automatic logic [63:0] beat_word(logic [`VGAFB_ADR_W-1:0] a, int k);
		logic [63:0] w;
		int s;
		w = '0;
		for (s = 0; s < 4; s++)
			w[63-16*s -: 16] = 16'((a >> 1) + `VGAFB_ADR_W'(4*k + s));
		beat_word = w;
	endfunction

	// n-th pixel of the stream, wraps at the end of the frame
	function automatic logic [15:0] expected_pixel(logic [`VGAFB_ADR_W-1:0] base, int nb, int n);
		int j;
		int k;
		int s;
		logic [`VGAFB_ADR_W-1:0] a;
		j = n % (nb * 16);
		k = (j % 16) / 4;
		s = j % 4;
		a = base + `VGAFB_ADR_W'(32 * (j / 16));
		expected_pixel = 16'((a >> 1) + `VGAFB_ADR_W'(4*k + s));
	endfunction

	function automatic test_row_t make_row(logic [`VGAFB_ADR_W-1:0] base, int nb, int lat,
			bit gaps, int reqs, bit mid, int frames);
		test_row_t r;
		r.base = base;
		r.nbursts = `VGAFB_NBURST_W'(nb);
		r.latency = 4'(lat);
		r.gaps = gaps;
		r.exp_reqs = 8'(reqs);
		r.mid_rst = mid;
		r.frames = 2'(frames);
		make_row = r;
	endfunction

	// worst case per pixel, latency plus slack
	function automatic int timeout_budget();
		int i;
		int sum;
		sum = 0;
		for (i = 0; i < NUM_TESTS; i++)
			sum += int'(table_rows[i].nbursts) * 16 * int'(table_rows[i].frames)
				* (int'(table_rows[i].latency) + 8);
		timeout_budget = sum;
	endfunction

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// DRAM model, ack after the row latency then three more beats
	always @(posedge sys_clk) begin
		if (sys_rst) begin
			fml_rsp <= '0;
			dram_wait <= 0;
			dram_beat <= 0;
		end else if (dram_beat != 0) begin
			fml_rsp.ack <= 1'b0;
			fml_rsp.dat <= beat_word(dram_adr, dram_beat);
			dram_beat <= (dram_beat == 3) ? 0 : dram_beat + 1;
		end else if (fml_req.stb) begin
			if (dram_wait + 1 >= cur_latency) begin
				fml_rsp.ack <= 1'b1;
				fml_rsp.dat <= beat_word(fml_req.adr, 0);
				dram_adr <= fml_req.adr;
				dram_beat <= 1;
				dram_wait <= 0;
			end else begin
				dram_wait <= dram_wait + 1;
			end
		end else begin
			fml_rsp.ack <= 1'b0;
		end
	end

	// accepted DRAM requests, base_ack pulses, watchdog
	always @(posedge sys_clk) begin
		if (!sys_rst) begin
			if (fml_req.stb && fml_rsp.ack)
				req_total <= req_total + 1;
			if (base_ack)
				base_total <= base_total + 1;
		end
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: pixel stream stalled after %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// new config under vga_rst, long enough for a DRAM access to drain
	task automatic restart_frame(input test_row_t row);
		@(posedge sys_clk);
		cfg.base <= row.base;
		cfg.nbursts <= row.nbursts;
		cur_latency <= int'(row.latency);
		vga_rst <= 1'b1;
		pixel_ack <= 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		vga_rst <= 1'b0;
	endtask

	// pulse vga_rst while the first request waits for its ack
	task automatic interrupt_dram_wait(input string name);
		int i;
		@(negedge sys_clk);
		while (!fml_req.stb)
			@(negedge sys_clk);
		repeat (2) @(negedge sys_clk);
		@(posedge sys_clk);
		vga_rst <= 1'b1;
		for (i = 0; i < 3; i++) begin
			@(negedge sys_clk);
			if (!fml_req.stb) begin
				$display("test %s: DRAM request was dropped during vga_rst", name);
				row_errors++;
			end
		end
		@(posedge sys_clk);
		vga_rst <= 1'b0;
	endtask

	initial begin
		int t;
		int n;
		int total;
		int req_start;
		int base_start;
		int reqs;
		int bases;
		int exp_bases;
		logic [15:0] exp_pix;
		test_row_t row;
		test_names[0] = "cold_frame";
		table_rows[0] = make_row(26'h1000, 8, 4, 1'b0, 8, 1'b0, 1);
		test_names[1] = "repeat_frame";
		table_rows[1] = make_row(26'h1000, 8, 4, 1'b0, 0, 1'b0, 1);
		test_names[2] = "frame_wrap";
		table_rows[2] = make_row(26'h1000, 4, 3, 1'b0, 0, 1'b0, 2);
		test_names[3] = "conflict_base";
		table_rows[3] = make_row(26'h1200, 8, 6, 1'b0, 8, 1'b0, 1);
		test_names[4] = "stalled_consumer";
		table_rows[4] = make_row(26'h2000, 4, 7, 1'b1, 4, 1'b0, 1);
		test_names[5] = "vga_rst_in_wait";
		table_rows[5] = make_row(26'h3000, 4, 9, 1'b0, 4, 1'b1, 1);
		cycle_limit = RST_CYCLES + timeout_budget();
		sys_rst = 1'b1;
		vga_rst = 1'b1;
		cfg = '0;
		pixel_ack = 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		sys_rst <= 1'b0;
		for (t = 0; t < NUM_TESTS; t++) begin
			row = table_rows[t];
			row_errors = 0;
			reqs = 0;
			bases = 0;
			restart_frame(row);
			@(negedge sys_clk);
			req_start = req_total;
			base_start = base_total;
			if (row.mid_rst)
				interrupt_dram_wait(test_names[t]);
			total = int'(row.nbursts) * 16 * int'(row.frames);
			n = 0;
			while (n < total) begin
				// ack seen at negedge is taken on the next rising edge
				@(negedge sys_clk);
				if (pixel_valid && pixel_ack) begin
					exp_pix = expected_pixel(row.base, int'(row.nbursts), n);
					if (pixel !== exp_pix) begin
						$display("** Error test %s: pixel %0d expected %h actual %h",
							test_names[t], n, exp_pix, pixel);
						row_errors++;
					end
					n++;
					if (n == total) begin
						reqs = req_total - req_start;
						bases = base_total - base_start;
					end
				end
				@(posedge sys_clk);
				if (n < total)
					pixel_ack <= row.gaps ? 1'($random(seed)) : 1'b1;
				else
					pixel_ack <= 1'b0;
			end
			if (reqs != int'(row.exp_reqs)) begin
				$display("** Error test %s: DRAM requests expected %0d actual %0d",
					test_names[t], row.exp_reqs, reqs);
				row_errors++;
			end
			// restart inside the row gives one more base_ack
			exp_bases = int'(row.frames) + (row.mid_rst ? 1 : 0);
			if (bases != exp_bases) begin
				$display("** Error test %s: base_ack pulses expected %0d actual %0d",
					test_names[t], exp_bases, bases);
				row_errors++;
			end
			if (row_errors == 0)
				$display("test %s: ok, %0d pixels, %0d DRAM requests", test_names[t], total, reqs);
			else
				$display("test %s: %0d errors", test_names[t], row_errors);
			if (row_errors != 0)
				failed_tests++;
			errors += row_errors;
		end
		errors += vgafb_fetch_top_inst.vgafb_pixelfeed_inst.vgafb_properties_inst.violations;
		$display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* flist.f */
+incdir+common
common/fml_pkg.sv
common/vgafb_pkg.sv
vgafb/vgafb_fifo64to16.sv
vgafb/vgafb_pixelfeed.sv
src/vgafb_line_cache.sv
src/vgafb_fetch_top.sv
dv/vgafb_properties.sv
dv/vgafb_tb.sv

/* Bender.yml */
package:
  name: vgafb_fetch

sources:
  - include_dirs:
      - common
    files:
      - common/fml_pkg.sv
      - common/vgafb_pkg.sv
      - vgafb/vgafb_fifo64to16.sv
      - vgafb/vgafb_pixelfeed.sv
      - src/vgafb_line_cache.sv
      - src/vgafb_fetch_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/vgafb_properties.sv
      - dv/vgafb_tb.sv
